// File: bbc_pkg.sv
// Shared widths, command and state encodings and the report format of the basic block counter.

package bbc_pkg;

    // ****************************************
    // Widths and scalar types
    // ****************************************

    localparam int WORD_W   = 16;                 // Block number width, counts wrap at 2^16.
    localparam int THREAD_W = 3;                  // Thread id width, up to 8 threads.

    typedef logic [WORD_W-1:0]   count_t;         // One block number.
    typedef logic [THREAD_W-1:0] thread_t;        // One hardware thread id.

    // ****************************************
    // Commands and controller states
    // ****************************************

    // Sampled on every rising clock edge by the controller.
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,                         // No effect.
        CMD_CLEAR = 2'd1,                         // Start a clear sweep.
        CMD_HOLD  = 2'd2,                         // Stop counting, keep the counts.
        CMD_RUN   = 2'd3                          // Resume counting.
    } bbc_cmd_t;

    typedef enum logic [1:0] {
        ST_CLEAR = 2'd0,                          // Zeroing one thread per slot.
        ST_RUN   = 2'd1,                          // Counting block-end events.
        ST_HOLD  = 2'd2                           // Events ignored, counts kept.
    } ctrl_state_t;

    // ****************************************
    // Report word
    // ****************************************

    // One counted event as seen at the top level, 20 bits in all.
    typedef struct packed {
        logic    valid;                           // High for one cycle per counted event.
        thread_t thread;                          // Thread that ended the basic block.
        count_t  block_number;                    // Value after the increment.
    } bbc_report_t;

endpackage

// File: ram_sdp_no_fw.sv
// Simple dual-port block RAM with a registered read port and no write-to-read forwarding.

`timescale 1ns/1ps

module ram_sdp_no_fw #(
    parameter int WORD_W = 16,
    parameter int DEPTH  = 8,
    parameter int ADDR_W = 3
) (
    input  logic              clock,
    input  logic              wren,
    input  logic [ADDR_W-1:0] write_addr,
    input  logic [WORD_W-1:0] write_data,
    input  logic [ADDR_W-1:0] read_addr,
    output logic [WORD_W-1:0] read_data
);

    // ****************************************
    // Storage
    // ****************************************

    logic [WORD_W-1:0] mem [DEPTH];              // Contents are set by the clear sweep.

    // ****************************************
    // Write port
    // ****************************************

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;       // Lands at the end of the write cycle.
        end
    end

    // ****************************************
    // Read port
    // ****************************************

    // A read of the word being written in the same cycle sees the old
    // contents, since both ports sample the array on the same edge.
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];             // Valid one cycle after the address.
    end

endmodule

// File: delay_line.sv
// Register chain that delays a word by a fixed number of clock stages.

`timescale 1ns/1ps

module delay_line #(
    parameter int DEPTH = 2,
    parameter int WIDTH = 16
) (
    input  logic             clock,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    if (DEPTH == 0) begin : g_wire
        assign data_out = data_in;               // No stages, straight through.
    end else begin : g_chain
        logic [WIDTH-1:0] stage [DEPTH];         // stage[0] is the newest word.

        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                for (int i = 0; i < DEPTH; i++) begin
                    stage[i] <= '0;
                end
            end else begin
                stage[0] <= data_in;
                for (int i = 1; i < DEPTH; i++) begin
                    stage[i] <= stage[i-1];      // Shift one place per clock.
                end
            end
        end

        assign data_out = stage[DEPTH-1];
    end

endmodule

// File: thread_sequencer.sv
// Barrel thread sequencer issuing one thread slot per clock in round-robin order.

`timescale 1ns/1ps

module thread_sequencer #(
    parameter int THREADS = 8
) (
    input  logic              clock,
    input  logic              rst_n,
    output bbc_pkg::thread_t  issue_thread,
    output logic              wrap
);

    localparam bbc_pkg::thread_t LAST_SLOT = bbc_pkg::thread_t'(THREADS - 1);

    // ****************************************
    // Slot counter
    // ****************************************

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            issue_thread <= '0;                  // First slot after reset is thread 0.
        end else if (wrap) begin
            issue_thread <= '0;                  // Start the next rotation.
        end else begin
            issue_thread <= issue_thread + 1'b1;
        end
    end

    // Marks the last slot of each rotation.
    assign wrap = (issue_thread == LAST_SLOT);

    // ****************************************
    // Checks
    // ****************************************

    // The RAM has THREADS words, so a slot past the last thread would
    // read and write outside of it.
    a_slot_in_range : assert property (
        @(posedge clock) disable iff (!rst_n)
        int'(issue_thread) < THREADS
    ) else $error("thread slot %0d out of range", issue_thread);

endmodule

// File: counter_control.sv
// Counter controller FSM for the clear sweep, hold and run states.

`timescale 1ns/1ps

module counter_control (
    input  logic              clock,
    input  logic              rst_n,
    input  bbc_pkg::bbc_cmd_t cmd,
    input  bbc_pkg::thread_t  issue_thread,
    input  logic              wrap,
    output logic              count_en,
    output logic              clear_en
);

    bbc_pkg::ctrl_state_t state;
    bbc_pkg::ctrl_state_t state_next;

    logic             mid_start;                 // Sweep began away from slot 0.
    bbc_pkg::thread_t end_slot;                  // Slot the command was sampled in.
    logic             sweep_done;

    // ****************************************
    // Sweep tracking
    // ****************************************

    // An aligned sweep ends on wrap, one started mid-rotation ends on the
    // slot just before its first slot.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mid_start <= 1'b0;                   // The reset sweep starts at thread 0.
            end_slot  <= '0;
        end else if (state != bbc_pkg::ST_CLEAR && cmd == bbc_pkg::CMD_CLEAR) begin
            mid_start <= !wrap;
            end_slot  <= issue_thread;
        end
    end

    assign sweep_done = mid_start ? (issue_thread == end_slot) : wrap;

    // ****************************************
    // State register and transitions
    // ****************************************

    always_comb begin
        state_next = state;
        case (state)
            bbc_pkg::ST_CLEAR: begin
                if (sweep_done) state_next = bbc_pkg::ST_RUN;  // Commands are ignored here.
            end
            bbc_pkg::ST_RUN: begin
                if (cmd == bbc_pkg::CMD_CLEAR)     state_next = bbc_pkg::ST_CLEAR;
                else if (cmd == bbc_pkg::CMD_HOLD) state_next = bbc_pkg::ST_HOLD;
            end
            bbc_pkg::ST_HOLD: begin
                if (cmd == bbc_pkg::CMD_CLEAR)    state_next = bbc_pkg::ST_CLEAR;
                else if (cmd == bbc_pkg::CMD_RUN) state_next = bbc_pkg::ST_RUN;
            end
            default: state_next = bbc_pkg::ST_CLEAR;         // Unused encoding.
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= bbc_pkg::ST_CLEAR;          // Counts are unknown until swept.
        end else begin
            state <= state_next;
        end
    end

    assign count_en = (state == bbc_pkg::ST_RUN);
    assign clear_en = (state == bbc_pkg::ST_CLEAR);

    // ****************************************
    // Checks
    // ****************************************

    // A write-back and a clear write must never compete for the RAM port.
    a_run_clear_excl : assert property (
        @(posedge clock) disable iff (!rst_n)
        !(count_en && clear_en)
    ) else $error("count and clear enabled together");

endmodule

// File: basic_block_counter.sv
// Per-thread basic block counter with a read, increment and write-back pipeline.

`timescale 1ns/1ps

module basic_block_counter #(
    parameter int THREADS     = 8,
    parameter int READ_STAGES = 2,
    parameter int INCR_STAGES = 2
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  bbc_pkg::thread_t     issue_thread,
    input  logic                 block_end,
    input  logic                 count_en,
    input  logic                 clear_en,
    output bbc_pkg::bbc_report_t report
);

    // Thread id and event bit travelling beside the block number.
    typedef struct packed {
        logic             hit;
        bbc_pkg::thread_t thread;
    } tag_t;

    localparam int TAG_W = $bits(tag_t);

    tag_t             tag_issue, tag_incr, tag_write;
    bbc_pkg::count_t  block_number;              // RAM output, stage 1.
    bbc_pkg::count_t  block_number_pre_incr;     // Stage 1 + READ_STAGES.
    bbc_pkg::count_t  block_number_incr;
    bbc_pkg::count_t  block_number_post_incr;    // Stage 1 + READ_STAGES + INCR_STAGES.
    logic             wren;
    bbc_pkg::thread_t write_thread;
    bbc_pkg::count_t  write_data;

    // ****************************************
    // Block number storage
    // ****************************************

    ram_sdp_no_fw #(
        .WORD_W (bbc_pkg::WORD_W),
        .DEPTH  (THREADS),
        .ADDR_W (bbc_pkg::THREAD_W)
    ) i_ram (
        .clock      (clock),
        .wren       (wren),
        .write_addr (write_thread),
        .write_data (write_data),
        .read_addr  (issue_thread),              // Every slot reads its own thread.
        .read_data  (block_number)
    );

    // ****************************************
    // Data path
    // ****************************************

    delay_line #(.DEPTH(READ_STAGES), .WIDTH(bbc_pkg::WORD_W)) i_dly_raw (
        .clock (clock), .rst_n (rst_n),
        .data_in (block_number), .data_out (block_number_pre_incr)
    );

    assign block_number_incr = block_number_pre_incr + bbc_pkg::count_t'(1);  // Wraps at 2^16.

    delay_line #(.DEPTH(INCR_STAGES), .WIDTH(bbc_pkg::WORD_W)) i_dly_cooked (
        .clock (clock), .rst_n (rst_n),
        .data_in (block_number_incr), .data_out (block_number_post_incr)
    );

    // ****************************************
    // Tag path
    // ****************************************

    assign tag_issue = '{hit: block_end && count_en, thread: issue_thread};

    // One extra stage matches the registered RAM read.
    delay_line #(.DEPTH(1 + READ_STAGES), .WIDTH(TAG_W)) i_dly_tag_raw (
        .clock (clock), .rst_n (rst_n), .data_in (tag_issue), .data_out (tag_incr)
    );

    delay_line #(.DEPTH(INCR_STAGES), .WIDTH(TAG_W)) i_dly_tag_cooked (
        .clock (clock), .rst_n (rst_n), .data_in (tag_incr), .data_out (tag_write)
    );

    // ****************************************
    // Write port and report
    // ****************************************

    // The clear sweep takes the write port, write-backs in flight are lost.
    assign wren         = clear_en || tag_write.hit;
    assign write_thread = clear_en ? issue_thread : tag_write.thread;
    assign write_data   = clear_en ? '0 : block_number_post_incr;

    assign report = '{valid:        tag_write.hit,
                      thread:       tag_write.thread,
                      block_number: block_number_post_incr};

    // The write-back must land before the same thread is read again.
    a_depth_fits : assert property (
        @(posedge clock) (1 + READ_STAGES + INCR_STAGES) < THREADS
    ) else $error("pipeline depth does not fit in one thread rotation");

endmodule

// File: bbc_top.sv
// Top level of the per-thread basic block counter for a barrel-scheduled processor.

`timescale 1ns/1ps

module bbc_top #(
    parameter int THREADS     = 8,               // Legal from 6 to 8.
    parameter int READ_STAGES = 2,
    parameter int INCR_STAGES = 2
) (
    input  logic                 clock,
    input  logic                 rst_n,
    input  bbc_pkg::bbc_cmd_t    cmd,
    input  logic                 block_end,
    output bbc_pkg::thread_t     issue_thread,
    output logic                 busy,
    output bbc_pkg::bbc_report_t report
);

    logic wrap;                                  // Last slot of the rotation.
    logic count_en;
    logic clear_en;

    // ****************************************
    // Thread slots
    // ****************************************

    thread_sequencer #(
        .THREADS (THREADS)
    ) i_thread_sequencer (
        .clock        (clock),
        .rst_n        (rst_n),
        .issue_thread (issue_thread),
        .wrap         (wrap)
    );

    // ****************************************
    // Control
    // ****************************************

    counter_control i_counter_control (
        .clock        (clock),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .issue_thread (issue_thread),
        .wrap         (wrap),
        .count_en     (count_en),
        .clear_en     (clear_en)
    );

    assign busy = clear_en;                      // High for the whole clear sweep.

    // ****************************************
    // Counter pipeline
    // ****************************************

    basic_block_counter #(
        .THREADS     (THREADS),
        .READ_STAGES (READ_STAGES),
        .INCR_STAGES (INCR_STAGES)
    ) i_basic_block_counter (
        .clock        (clock),
        .rst_n        (rst_n),
        .issue_thread (issue_thread),
        .block_end    (block_end),
        .count_en     (count_en),
        .clear_en     (clear_en),
        .report       (report)
    );

endmodule

// File: tb_bbc_top.sv
// Self-checking testbench for the basic block counter, driven from a patterns file.

`timescale 1ns/1ps

module tb_bbc_top;

    localparam int THREADS = 8;                  // DUT default thread count.
    localparam int LATENCY = 5;                  // 1 + READ_STAGES + INCR_STAGES.

    logic                 clock = 1'b0;
    logic                 rst_n;
    bbc_pkg::bbc_cmd_t    cmd;
    logic                 block_end;
    bbc_pkg::thread_t     issue_thread;
    logic                 busy;
    bbc_pkg::bbc_report_t report;

    // ****************************************
    // Reference model and bookkeeping
    // ****************************************

    bbc_pkg::count_t      model_count [THREADS];  // One block number per thread.
    bbc_pkg::ctrl_state_t model_state;
    bbc_pkg::thread_t     model_slot;            // Slot of the cycle being driven.
    int                   clear_left;            // Sweep cycles still to go.
    int                   cycle;
    logic                 last_busy;
    bbc_pkg::bbc_report_t exp_q [$];             // Reports still in the pipeline.
    int                   due_q [$];             // Cycle each of them shows up.
    int                   checks;
    int                   errors;
    bit                   stopped;
    string                step_op [$];
    int                   step_n [$];
    string                step_mask [$];
    string                step_exp [$];

    bbc_top i_bbc_top (
        .clock        (clock),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .block_end    (block_end),
        .issue_thread (issue_thread),
        .busy         (busy),
        .report       (report)
    );

    always #4 clock = ~clock;                    // 8 ns period.

    // ****************************************
    // Compare tasks
    // ****************************************

    task automatic check_report(input bbc_pkg::bbc_report_t got,
                                input bbc_pkg::bbc_report_t want);
        checks++;
        if (got.valid !== want.valid || (want.valid && got !== want)) begin
            errors++;
            $display("CHECK FAILED %0t: report %0b/%0d/%0d, expected %0b/%0d/%0d",
                     $time, got.valid, got.thread, got.block_number,
                     want.valid, want.thread, want.block_number);
        end
    endtask

    task automatic check_count(input bbc_pkg::count_t got, input bbc_pkg::count_t want,
                               input int thread_id);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %0t: thread %0d count %0d, expected %0d",
                     $time, thread_id, got, want);
        end
    endtask

    task automatic check_thread(input bbc_pkg::thread_t got, input bbc_pkg::thread_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %0t: issue_thread %0d, expected %0d", $time, got, want);
        end
    endtask

    task automatic check_busy(input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED %0t: busy %0b, expected %0b", $time, got, want);
        end
    endtask

    // ****************************************
    // One clock cycle of stimulus and checking
    // ****************************************

    task automatic drive_cycle(input bbc_pkg::bbc_cmd_t cmd_v, input logic [7:0] mask,
                               input bit use_rand);
        logic                 be;
        bbc_pkg::bbc_report_t exp_r;
        if (use_rand) begin
            be = ($urandom_range(1, 0) == 1);
        end else begin
            be = mask[model_slot];               // Mask bit of the slot about to issue.
        end
        cmd       <= cmd_v;
        block_end <= be;
        @(posedge clock);
        last_busy = busy;                        // Outputs still show the cycle just ended.
        check_thread(issue_thread, model_slot);
        check_busy(busy, model_state == bbc_pkg::ST_CLEAR);
        exp_r = '0;
        if (due_q.size() > 0 && due_q[0] == cycle) begin
            exp_r = exp_q.pop_front();
            due_q.delete(0);
        end
        check_report(report, exp_r);
        if (be && model_state == bbc_pkg::ST_RUN) begin
            model_count[model_slot] = model_count[model_slot] + bbc_pkg::count_t'(1);
            exp_r = '{valid: 1'b1, thread: model_slot, block_number: model_count[model_slot]};
            exp_q.push_back(exp_r);
            due_q.push_back(cycle + LATENCY);
        end
        case (model_state)
            bbc_pkg::ST_CLEAR: begin
                model_count[model_slot] = '0;    // Sweep zeroes one thread per slot.
                clear_left = clear_left - 1;
                if (clear_left == 0) model_state = bbc_pkg::ST_RUN;
            end
            bbc_pkg::ST_RUN: begin
                if (cmd_v == bbc_pkg::CMD_CLEAR) begin
                    model_state = bbc_pkg::ST_CLEAR;
                    clear_left  = THREADS;
                end else if (cmd_v == bbc_pkg::CMD_HOLD) begin
                    model_state = bbc_pkg::ST_HOLD;
                end
            end
            bbc_pkg::ST_HOLD: begin
                if (cmd_v == bbc_pkg::CMD_CLEAR) begin
                    model_state = bbc_pkg::ST_CLEAR;
                    clear_left  = THREADS;
                end else if (cmd_v == bbc_pkg::CMD_RUN) begin
                    model_state = bbc_pkg::ST_RUN;
                end
            end
            default: model_state = bbc_pkg::ST_CLEAR;
        endcase
        model_slot = (int'(model_slot) == THREADS - 1) ? '0 : model_slot + bbc_pkg::thread_t'(1);
        cycle++;
    endtask

    // A command goes out on the first cycle of its step only.
    task automatic run_step(input bbc_pkg::bbc_cmd_t cmd_v, input int cycles,
                            input logic [7:0] mask, input bit use_rand);
        for (int k = 0; k < cycles; k++) begin
            drive_cycle((k == 0) ? cmd_v : bbc_pkg::CMD_NOP, mask, use_rand);
        end
    endtask

    task automatic wait_not_busy(input int limit, input logic [7:0] mask, input bit use_rand);
        int waited;
        waited    = 0;
        last_busy = 1'b1;
        while (last_busy && waited < limit) begin
            drive_cycle(bbc_pkg::CMD_NOP, mask, use_rand);
            waited++;
        end
        if (last_busy) begin
            errors++;
            stopped = 1'b1;
            $display("Timeout: busy was still high after %0d cycles.", limit);
        end
    endtask

    task automatic wait_drained(input int limit, input logic [7:0] mask, input bit use_rand);
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < limit) begin
            drive_cycle(bbc_pkg::CMD_NOP, mask, use_rand);
            waited++;
        end
        if (exp_q.size() > 0) begin
            errors++;
            stopped = 1'b1;
            $display("Timeout: %0d reports still missing after %0d cycles.", exp_q.size(), limit);
        end
    endtask

    function automatic bbc_pkg::bbc_cmd_t cmd_from_name(input string name);
        if (name == "clear") return bbc_pkg::CMD_CLEAR;
        if (name == "hold") return bbc_pkg::CMD_HOLD;
        if (name == "run") return bbc_pkg::CMD_RUN;
        return bbc_pkg::CMD_NOP;
    endfunction

    // ****************************************
    // Main sequence
    // ****************************************

    initial begin
        int         fd;
        int         line_no;
        int         fields;
        int         n;
        int         want;
        int         tests;
        int         err_before;
        string      line;
        string      op;
        string      mask_s;
        string      exp_s;
        logic [7:0] mask_v;
        bit         use_rand;

        rst_n     <= 1'b0;
        cmd       <= bbc_pkg::CMD_NOP;
        block_end <= 1'b0;
        void'($urandom(19783));
        $timeformat(-9, 0, " ns", 0);
        checks      = 0;
        errors      = 0;
        tests       = 0;
        stopped     = 1'b0;
        model_count = '{default: '0};
        model_state = bbc_pkg::ST_CLEAR;         // The sweep starts right out of reset.
        model_slot  = '0;
        clear_left  = THREADS;
        cycle       = 0;

        fd = $fopen("bbc_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open bbc_patterns.txt, there are no steps to run.");
        end else begin
            line_no = 0;
            while ($fgets(line, fd) > 0) begin
                line_no++;
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %d %s %s", op, n, mask_s, exp_s);
                    if (fields == 4) begin
                        step_op.push_back(op);
                        step_n.push_back(n);
                        step_mask.push_back(mask_s);
                        step_exp.push_back(exp_s);
                    end else begin
                        errors++;
                        $display("Pattern line %0d is malformed.", line_no);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (8) @(posedge clock);
        rst_n <= 1'b1;                           // Cycle 0 starts on this edge.

        for (int i = 0; i < step_op.size() && !stopped; i++) begin
            err_before = errors;
            use_rand   = (step_mask[i] == "rand");
            mask_v     = '0;
            if (!use_rand && step_mask[i] != "-") begin
                fields = $sscanf(step_mask[i], "%h", mask_v);
            end
            op = step_op[i];
            if (op == "check") begin
                fields = $sscanf(step_exp[i], "%d", want);
                check_count(model_count[bbc_pkg::thread_t'(step_n[i])],
                            bbc_pkg::count_t'(want), step_n[i]);
            end else if (op == "idle") begin
                wait_not_busy(step_n[i], mask_v, use_rand);
            end else if (op == "drain") begin
                wait_drained(step_n[i], mask_v, use_rand);
            end else if (op == "nop" || op == "clear" || op == "hold" || op == "run") begin
                run_step(cmd_from_name(op), step_n[i], mask_v, use_rand);
            end else begin
                errors++;
                $display("Unknown operation %s in step %0d.", op, i + 1);
            end
            tests++;
            $display("Step %0d %s %0d %s: %s", i + 1, op, step_n[i], step_mask[i],
                     (errors == err_before) ? "ok" : "mismatch");
        end

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected reports never arrived.", exp_q.size());
        end
        $display("Steps %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: bbc_patterns.txt
# op count mask expected: op is nop, clear, hold, run, idle, drain or check; mask is hex per thread
# A command goes out on the first cycle of its step; on check lines count is the thread number
idle 20 00 -
nop 8 01 -
nop 8 90 -
drain 10 00 -
check 0 - 1
check 4 - 1
check 7 - 1
check 2 - 0
nop 80 ff -
drain 10 00 -
check 0 - 11
check 2 - 10
check 5 - 10
hold 1 00 -
nop 24 ff -
check 3 - 10
run 1 00 -
nop 16 24 -
drain 10 00 -
check 2 - 12
check 5 - 12
check 7 - 11
nop 16 ff -
clear 1 ff -
hold 2 00 -
idle 20 00 -
check 6 - 0
nop 8 ff -
drain 10 00 -
check 3 - 1
check 6 - 1
nop 200 rand -
drain 10 00 -
clear 1 00 -
idle 20 00 -
nop 400 rand -
drain 10 00 -

// File: compile.f
bbc_pkg.sv
ram_sdp_no_fw.sv
delay_line.sv
thread_sequencer.sv
counter_control.sv
basic_block_counter.sv
bbc_top.sv
tb_bbc_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_bbc_top -f compile.f -o tb_bbc_top &&
./obj_dir/tb_bbc_top | tee /dev/stderr | grep -F '** PASS **' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
